//--- flist.f
logic/soc_periph_pkg.sv
logic/periph_bus_decode.sv
logic/gpio_unit.sv
logic/ref_timer.sv
logic/fc_event_map.sv
logic/soc_periph_top.sv
dv/soc_periph_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the peripheral testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf build
verilator --binary --timing -f flist.f --top-module soc_periph_tb \
    -Mdir build -o soc_periph_sim

./build/soc_periph_sim | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- dv/soc_periph_tb.sv
`timescale 1ns/1ps

module soc_periph_tb
    import soc_periph_pkg::*;
();

    localparam int NGPIO        = 32;
    localparam int CLK_HALF     = 50;
    localparam int SLOW_HOLD    = 6;
    localparam int MAX_CMP      = 5;
    // Timer test dominates with two holds and one read per slow period
    localparam int TIMER_CYCLES = 2 * (MAX_CMP + 1) * (2 * SLOW_HOLD + 3);
    localparam int TEST_CYCLES  = TIMER_CYCLES + 250;
    localparam int WDOG_CYCLES  = TEST_CYCLES + 200;

    logic                clk;
    logic                rst_n;
    logic                slow_clk;
    logic                psel;
    logic                penable;
    logic                pwrite;
    periph_addr_u        paddr;
    logic [APB_DW-1:0]   pwdata;
    logic [APB_DW-1:0]   prdata;
    logic                pready;
    logic                pslverr;
    logic [NGPIO-1:0]    gpio_in;
    logic [NGPIO-1:0]    gpio_out;
    logic [NGPIO-1:0]    gpio_dir;
    logic                dma_pe_evt;
    logic                dma_pe_irq;
    logic                pf_evt;
    logic [FC_EVT_W-1:0] fc_events;

    int               errors;
    int               tests_run;
    int               timer_pulses;
    int               edge_pulses;
    logic [31:0]      rng_state;
    logic [NGPIO-1:0] dir_val;
    logic [NGPIO-1:0] out_val;
    logic [31:0]      compare_val;

    soc_periph_top #(
        .NGPIO ( NGPIO )
    ) DUT (
        .clk_i        ( clk        ),
        .rst_ni       ( rst_n      ),
        .slow_clk_i   ( slow_clk   ),
        .psel_i       ( psel       ),
        .penable_i    ( penable    ),
        .pwrite_i     ( pwrite     ),
        .paddr_i      ( paddr      ),
        .pwdata_i     ( pwdata     ),
        .prdata_o     ( prdata     ),
        .pready_o     ( pready     ),
        .pslverr_o    ( pslverr    ),
        .gpio_i       ( gpio_in    ),
        .gpio_out_o   ( gpio_out   ),
        .gpio_dir_o   ( gpio_dir   ),
        .dma_pe_evt_i ( dma_pe_evt ),
        .dma_pe_irq_i ( dma_pe_irq ),
        .pf_evt_i     ( pf_evt     ),
        .fc_events_o  ( fc_events  )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // Event pulses are counted once per cycle on the falling edge
    initial begin
        timer_pulses = 0;
        edge_pulses  = 0;
        forever begin
            @(negedge clk);
            if (fc_events[EVT_TIMER]) begin
                timer_pulses++;
            end
            if (fc_events[EVT_REF_EDGE]) begin
                edge_pulses++;
            end
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic report_mismatch(input string test, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("MISMATCH %s: expected %h, actual %h", test, exp, act);
        errors++;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic apb_setup(input logic [REGION_W-1:0] region, input logic [REG_IDX_W-1:0] idx,
                             input logic write, input logic [APB_DW-1:0] data);
        @(negedge clk);
        psel           = 1'b1;
        penable        = 1'b0;
        pwrite         = write;
        pwdata         = data;
        paddr          = '0;
        paddr.f.region  = region;
        paddr.f.reg_idx = idx;
    endtask

    task automatic apb_idle();
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [REGION_W-1:0] region, input logic [REG_IDX_W-1:0] idx,
                             input logic [APB_DW-1:0] data);
        apb_setup(region, idx, 1'b1, data);
        @(negedge clk);
        penable = 1'b1;
        apb_idle();
    endtask

    // Response sampled just after the access phase starts
    task automatic apb_read(input logic [REGION_W-1:0] region, input logic [REG_IDX_W-1:0] idx,
                            output logic [APB_DW-1:0] rd, output logic err, output logic rdy);
        apb_setup(region, idx, 1'b0, '0);
        @(negedge clk);
        penable = 1'b1;
        #1;
        rd  = prdata;
        err = pslverr;
        rdy = pready;
        apb_idle();
    endtask

    task automatic expect_read(input string test, input logic [REGION_W-1:0] region,
                               input logic [REG_IDX_W-1:0] idx, input logic [APB_DW-1:0] exp);
        logic [APB_DW-1:0] rd;
        logic              err;
        logic              rdy;
        apb_read(region, idx, rd, err, rdy);
        if (rd !== exp) report_mismatch(test, exp, rd);
        if (rdy !== 1'b1) report_mismatch(test, 32'd1, 32'(rdy));
        if (err !== 1'b0) report_mismatch(test, 32'd0, 32'(err));
    endtask

    task automatic drive_slow(input logic level);
        slow_clk = level;
        wait_cycles(SLOW_HOLD);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic test_reset();
        int i;
        tests_run++;
        if (fc_events !== '0) report_mismatch("reset", '0, fc_events);
        if (gpio_dir !== '0) report_mismatch("reset", '0, gpio_dir);
        if (gpio_out !== '0) report_mismatch("reset", '0, gpio_out);
        if (pslverr !== 1'b0) report_mismatch("reset", 32'd0, 32'(pslverr));
        // Index 5 is unknown and must read 0 as well
        for (i = 0; i <= 5; i++) begin
            expect_read("reset", REGION_GPIO, 6'(i), '0);
        end
        for (i = 0; i <= 2; i++) begin
            expect_read("reset", REGION_TIMER, 6'(i), '0);
        end
        expect_read("reset", REGION_SWEVT, '0, '0);
    endtask

    task automatic test_gpio_regs();
        logic [NGPIO-1:0] pins;
        tests_run++;
        dir_val = next_rand();
        out_val = next_rand();
        apb_write(REGION_GPIO, GPIO_DIR, dir_val);
        apb_write(REGION_GPIO, GPIO_OUT, out_val);
        expect_read("gpio_regs", REGION_GPIO, GPIO_DIR, dir_val);
        expect_read("gpio_regs", REGION_GPIO, GPIO_OUT, out_val);
        if (gpio_dir !== dir_val) report_mismatch("gpio_regs", dir_val, gpio_dir);
        if (gpio_out !== out_val) report_mismatch("gpio_regs", out_val, gpio_out);
        pins    = next_rand();
        gpio_in = pins;
        wait_cycles(4);
        expect_read("gpio_regs", REGION_GPIO, GPIO_IN, pins);
    endtask

    task automatic test_gpio_irq();
        logic [NGPIO-1:0] mask;
        logic [NGPIO-1:0] risen;
        logic [NGPIO-1:0] status;
        tests_run++;
        gpio_in = '0;
        wait_cycles(4);
        mask  = next_rand();
        risen = next_rand();
        apb_write(REGION_GPIO, GPIO_IRQ_EN, mask);
        gpio_in = risen;
        wait_cycles(4);
        status = mask & risen;
        expect_read("gpio_irq", REGION_GPIO, GPIO_IRQ_STATUS, status);
        if (fc_events[EVT_GPIO] !== |status) begin
            report_mismatch("gpio_irq", 32'(|status), 32'(fc_events[EVT_GPIO]));
        end
        // Write 1 to clear
        apb_write(REGION_GPIO, GPIO_IRQ_STATUS, status);
        wait_cycles(2);
        expect_read("gpio_irq", REGION_GPIO, GPIO_IRQ_STATUS, '0);
        if (fc_events[EVT_GPIO] !== 1'b0) begin
            report_mismatch("gpio_irq", 32'd0, 32'(fc_events[EVT_GPIO]));
        end
    endtask

    task automatic test_timer();
        int cmp_val;
        int k;
        int timer_start;
        int edge_start;
        tests_run++;
        cmp_val     = 2 + int'(next_rand() & 32'h3);
        compare_val = 32'(cmp_val);
        apb_write(REGION_TIMER, TMR_COMPARE, compare_val);
        apb_write(REGION_TIMER, TMR_CTRL, 32'h1);
        timer_start = timer_pulses;
        edge_start  = edge_pulses;
        // COUNT is read in the high half so a falling-edge tick would show
        for (k = 1; k <= 2 * (cmp_val + 1); k++) begin
            drive_slow(1'b1);
            expect_read("timer", REGION_TIMER, TMR_COUNT, 32'(k % (cmp_val + 1)));
            drive_slow(1'b0);
        end
        wait_cycles(1);
        if (timer_pulses - timer_start != 2) begin
            report_mismatch("timer", 32'd2, 32'(timer_pulses - timer_start));
        end
        // One pulse per slow edge in either direction
        if (edge_pulses - edge_start != 4 * (cmp_val + 1)) begin
            report_mismatch("timer", 32'(4 * (cmp_val + 1)), 32'(edge_pulses - edge_start));
        end
        apb_write(REGION_TIMER, TMR_CTRL, 32'h0);
    endtask

    task automatic test_sw_events();
        logic [APB_DW-1:0] pat;
        logic [2:0]        ext;
        logic [2:0]        got;
        int                i;
        tests_run++;
        pat = next_rand();
        apb_write(REGION_SWEVT, '0, pat);
        if (fc_events[SWEVT_W-1:0] !== '0) begin
            report_mismatch("sw_events", '0, 32'(fc_events[SWEVT_W-1:0]));
        end
        wait_cycles(1);
        if (fc_events[SWEVT_W-1:0] !== pat[SWEVT_W-1:0]) begin
            report_mismatch("sw_events", 32'(pat[SWEVT_W-1:0]), 32'(fc_events[SWEVT_W-1:0]));
        end
        wait_cycles(1);
        if (fc_events[SWEVT_W-1:0] !== '0) begin
            report_mismatch("sw_events", '0, 32'(fc_events[SWEVT_W-1:0]));
        end
        for (i = 0; i < 9; i++) begin
            ext = (i < 8) ? 3'(i) : 3'b000;
            {pf_evt, dma_pe_irq, dma_pe_evt} = ext;
            wait_cycles(1);
            got = {fc_events[EVT_PF], fc_events[EVT_DMA_IRQ], fc_events[EVT_DMA_PE]};
            if (got !== ext) report_mismatch("ext_events", 32'(ext), 32'(got));
        end
    endtask

    task automatic test_unmapped();
        logic [APB_DW-1:0] rd;
        logic              err;
        logic              rdy;
        int                i;
        tests_run++;
        apb_read(4'd5, GPIO_DIR, rd, err, rdy);
        if (err !== 1'b1) report_mismatch("unmapped", 32'd1, 32'(err));
        if (rd !== '0) report_mismatch("unmapped", '0, rd);
        if (rdy !== 1'b1) report_mismatch("unmapped", 32'd1, 32'(rdy));
        for (i = 0; i < 5; i++) begin
            apb_write(4'd5, 6'(i), 32'hffff_ffff);
        end
        expect_read("unmapped", REGION_GPIO, GPIO_DIR, dir_val);
        expect_read("unmapped", REGION_GPIO, GPIO_OUT, out_val);
        expect_read("unmapped", REGION_TIMER, TMR_CTRL, '0);
        expect_read("unmapped", REGION_TIMER, TMR_COUNT, '0);
        expect_read("unmapped", REGION_TIMER, TMR_COMPARE, compare_val);
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////
    initial begin
        rng_state   = 32'h0e2d4cf8;
        errors      = 0;
        tests_run   = 0;
        dir_val     = '0;
        out_val     = '0;
        compare_val = '0;
        rst_n       = 1'b0;
        slow_clk    = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        gpio_in     = '0;
        dma_pe_evt  = 1'b0;
        dma_pe_irq  = 1'b0;
        pf_evt      = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_gpio_regs();
        test_gpio_irq();
        test_timer();
        test_sw_events();
        test_unmapped();

        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, tests did not finish", WDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- logic/soc_periph_top.sv
`timescale 1ns/1ps

module soc_periph_top
    import soc_periph_pkg::*;
#(
    parameter int NGPIO = NGPIO_DEFAULT
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                slow_clk_i,
    // APB slave
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  periph_addr_u        paddr_i,
    input  logic [APB_DW-1:0]   pwdata_i,
    output logic [APB_DW-1:0]   prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    // Pads
    input  logic [NGPIO-1:0]    gpio_i,
    output logic [NGPIO-1:0]    gpio_out_o,
    output logic [NGPIO-1:0]    gpio_dir_o,
    // External events
    input  logic                dma_pe_evt_i,
    input  logic                dma_pe_irq_i,
    input  logic                pf_evt_i,
    output logic [FC_EVT_W-1:0] fc_events_o
);

    logic                 gpio_we;
    logic                 tmr_we;
    logic                 swevt_we;
    logic [REG_IDX_W-1:0] reg_idx;
    logic [APB_DW-1:0]    wdata;
    logic [APB_DW-1:0]    gpio_rdata;
    logic [APB_DW-1:0]    tmr_rdata;
    logic [APB_DW-1:0]    swevt_rdata;
    logic                 gpio_irq;
    logic                 timer_irq;
    logic                 ref_edge;

    periph_bus_decode i_bus_decode (
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .pwrite_i      ( pwrite_i    ),
        .paddr_i       ( paddr_i     ),
        .pwdata_i      ( pwdata_i    ),
        .gpio_rdata_i  ( gpio_rdata  ),
        .tmr_rdata_i   ( tmr_rdata   ),
        .swevt_rdata_i ( swevt_rdata ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   ),
        .gpio_we_o     ( gpio_we     ),
        .tmr_we_o      ( tmr_we      ),
        .swevt_we_o    ( swevt_we    ),
        .reg_idx_o     ( reg_idx     ),
        .wdata_o       ( wdata       )
    );

    gpio_unit #(
        .NGPIO ( NGPIO )
    ) i_gpio (
        .clk_i      ( clk_i      ),
        .rst_ni     ( rst_ni     ),
        .we_i       ( gpio_we    ),
        .reg_idx_i  ( reg_idx    ),
        .wdata_i    ( wdata      ),
        .gpio_i     ( gpio_i     ),
        .rdata_o    ( gpio_rdata ),
        .gpio_out_o ( gpio_out_o ),
        .gpio_dir_o ( gpio_dir_o ),
        .gpio_irq_o ( gpio_irq   )
    );

    ref_timer i_timer (
        .clk_i       ( clk_i      ),
        .rst_ni      ( rst_ni     ),
        .we_i        ( tmr_we     ),
        .reg_idx_i   ( reg_idx    ),
        .wdata_i     ( wdata      ),
        .slow_clk_i  ( slow_clk_i ),
        .rdata_o     ( tmr_rdata  ),
        .timer_irq_o ( timer_irq  ),
        .ref_edge_o  ( ref_edge   )
    );

    fc_event_map i_event_map (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .we_i         ( swevt_we     ),
        .wdata_i      ( wdata        ),
        .gpio_irq_i   ( gpio_irq     ),
        .timer_irq_i  ( timer_irq    ),
        .ref_edge_i   ( ref_edge     ),
        .dma_pe_evt_i ( dma_pe_evt_i ),
        .dma_pe_irq_i ( dma_pe_irq_i ),
        .pf_evt_i     ( pf_evt_i     ),
        .rdata_o      ( swevt_rdata  ),
        .fc_events_o  ( fc_events_o  )
    );

endmodule

//--- logic/fc_event_map.sv
`timescale 1ns/1ps

module fc_event_map
    import soc_periph_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                we_i,
    input  logic [APB_DW-1:0]   wdata_i,
    input  logic                gpio_irq_i,
    input  logic                timer_irq_i,
    input  logic                ref_edge_i,
    input  logic                dma_pe_evt_i,
    input  logic                dma_pe_irq_i,
    input  logic                pf_evt_i,
    output logic [APB_DW-1:0]   rdata_o,
    output logic [FC_EVT_W-1:0] fc_events_o
);

    logic [SWEVT_W-1:0]  swevt_q;
    logic [FC_EVT_W-1:0] events_d;

    // Software events live for one cycle after the write
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            swevt_q <= '0;
        end else begin
            swevt_q <= we_i ? wdata_i[SWEVT_W-1:0] : '0;
        end
    end

    // Write-only region
    assign rdata_o = '0;

    ////////////////////////////////////////
    // Event word assembly
    ////////////////////////////////////////
    always_comb begin
        events_d                = '0;
        events_d[SWEVT_W-1:0]   = swevt_q;
        events_d[EVT_DMA_PE]    = dma_pe_evt_i;
        events_d[EVT_DMA_IRQ]   = dma_pe_irq_i;
        events_d[EVT_TIMER]     = timer_irq_i;
        events_d[EVT_PF]        = pf_evt_i;
        events_d[EVT_REF_EDGE]  = ref_edge_i;
        events_d[EVT_GPIO]      = gpio_irq_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fc_events_o <= '0;
        end else begin
            fc_events_o <= events_d;
        end
    end

endmodule

//--- logic/ref_timer.sv
`timescale 1ns/1ps

module ref_timer
    import soc_periph_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 we_i,
    input  logic [REG_IDX_W-1:0] reg_idx_i,
    input  logic [APB_DW-1:0]    wdata_i,
    input  logic                 slow_clk_i,
    output logic [APB_DW-1:0]    rdata_o,
    output logic                 timer_irq_o,
    output logic                 ref_edge_o
);

    logic              slow1_q;
    logic              slow2_q;
    logic              slow_prev_q;
    logic              slow_rise;
    logic              enable_q;
    logic [APB_DW-1:0] count_q;
    logic [APB_DW-1:0] compare_q;
    logic              irq_q;

    ////////////////////////////////////////
    // Slow clock sync and edge detect
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            slow1_q     <= 1'b0;
            slow2_q     <= 1'b0;
            slow_prev_q <= 1'b0;
        end else begin
            slow1_q     <= slow_clk_i;
            slow2_q     <= slow1_q;
            slow_prev_q <= slow2_q;
        end
    end

    assign slow_rise  = slow2_q & ~slow_prev_q;
    // Either edge of the reference clock
    assign ref_edge_o = slow2_q ^ slow_prev_q;

    ////////////////////////////////////////
    // Counter
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q  <= 1'b0;
            count_q   <= '0;
            compare_q <= '0;
            irq_q     <= 1'b0;
        end else begin
            irq_q <= 1'b0;
            if (we_i && (reg_idx_i == TMR_CTRL)) begin
                enable_q <= wdata_i[0];
            end
            if (we_i && (reg_idx_i == TMR_COMPARE)) begin
                compare_q <= wdata_i;
            end
            // Software write to COUNT overrides a tick in the same cycle
            if (we_i && (reg_idx_i == TMR_COUNT)) begin
                count_q <= wdata_i;
            end else if (enable_q && slow_rise) begin
                if (count_q == compare_q) begin
                    count_q <= '0;
                    irq_q   <= 1'b1;
                end else begin
                    count_q <= count_q + 1'b1;
                end
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        case (reg_idx_i)
            TMR_CTRL:    rdata_o[0] = enable_q;
            TMR_COUNT:   rdata_o    = count_q;
            TMR_COMPARE: rdata_o    = compare_q;
            default:     rdata_o    = '0;
        endcase
    end

    assign timer_irq_o = irq_q;

endmodule

//--- logic/gpio_unit.sv
`timescale 1ns/1ps

module gpio_unit
    import soc_periph_pkg::*;
#(
    parameter int NGPIO = NGPIO_DEFAULT
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 we_i,
    input  logic [REG_IDX_W-1:0] reg_idx_i,
    input  logic [APB_DW-1:0]    wdata_i,
    input  logic [NGPIO-1:0]     gpio_i,
    output logic [APB_DW-1:0]    rdata_o,
    output logic [NGPIO-1:0]     gpio_out_o,
    output logic [NGPIO-1:0]     gpio_dir_o,
    output logic                 gpio_irq_o
);

    logic [NGPIO-1:0] dir_q;
    logic [NGPIO-1:0] out_q;
    logic [NGPIO-1:0] irq_en_q;
    logic [NGPIO-1:0] status_q;
    logic [NGPIO-1:0] sync1_q;
    logic [NGPIO-1:0] sync2_q;
    logic [NGPIO-1:0] prev_q;
    logic [NGPIO-1:0] rise;
    logic [NGPIO-1:0] status_clr;
    logic [NGPIO-1:0] wbits;

    assign wbits = wdata_i[NGPIO-1:0];

    ////////////////////////////////////////
    // Input synchronizer and edge detect
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    assign rise = sync2_q & ~prev_q;

    // A new edge in the same cycle wins over a write-1 clear
    assign status_clr = (we_i && (reg_idx_i == GPIO_IRQ_STATUS)) ? wbits : '0;

    ////////////////////////////////////////
    // Software registers
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dir_q    <= '0;
            out_q    <= '0;
            irq_en_q <= '0;
            status_q <= '0;
        end else begin
            if (we_i && (reg_idx_i == GPIO_DIR)) begin
                dir_q <= wbits;
            end
            if (we_i && (reg_idx_i == GPIO_OUT)) begin
                out_q <= wbits;
            end
            if (we_i && (reg_idx_i == GPIO_IRQ_EN)) begin
                irq_en_q <= wbits;
            end
            status_q <= (status_q & ~status_clr) | (rise & irq_en_q);
        end
    end

    always_comb begin
        rdata_o = '0;
        case (reg_idx_i)
            GPIO_DIR:        rdata_o[NGPIO-1:0] = dir_q;
            GPIO_OUT:        rdata_o[NGPIO-1:0] = out_q;
            GPIO_IN:         rdata_o[NGPIO-1:0] = sync2_q;
            GPIO_IRQ_EN:     rdata_o[NGPIO-1:0] = irq_en_q;
            GPIO_IRQ_STATUS: rdata_o[NGPIO-1:0] = status_q;
            default:         rdata_o = '0;
        endcase
    end

    assign gpio_dir_o = dir_q;
    assign gpio_out_o = out_q;
    assign gpio_irq_o = |status_q;

endmodule

//--- logic/periph_bus_decode.sv
`timescale 1ns/1ps

module periph_bus_decode
    import soc_periph_pkg::*;
(
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  periph_addr_u         paddr_i,
    input  logic [APB_DW-1:0]    pwdata_i,
    input  logic [APB_DW-1:0]    gpio_rdata_i,
    input  logic [APB_DW-1:0]    tmr_rdata_i,
    input  logic [APB_DW-1:0]    swevt_rdata_i,
    output logic [APB_DW-1:0]    prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o,
    output logic                 gpio_we_o,
    output logic                 tmr_we_o,
    output logic                 swevt_we_o,
    output logic [REG_IDX_W-1:0] reg_idx_o,
    output logic [APB_DW-1:0]    wdata_o
);

    logic                access;
    logic                wr_access;
    logic                mapped;
    logic [REGION_W-1:0] region;

    assign region    = paddr_i.f.region;
    assign access    = psel_i & penable_i;
    assign wr_access = access & pwrite_i;

    // Zero wait states so every access ends in its access phase
    assign pready_o = 1'b1;

    // Register index and data are shared by all regions
    assign reg_idx_o = paddr_i.f.reg_idx;
    assign wdata_o   = pwdata_i;

    // Per-region write strobes
    assign gpio_we_o  = wr_access && (region == REGION_GPIO);
    assign tmr_we_o   = wr_access && (region == REGION_TIMER);
    assign swevt_we_o = wr_access && (region == REGION_SWEVT);

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////
    always_comb begin
        mapped   = 1'b1;
        prdata_o = '0;
        case (region)
            REGION_GPIO:  prdata_o = gpio_rdata_i;
            REGION_TIMER: prdata_o = tmr_rdata_i;
            REGION_SWEVT: prdata_o = swevt_rdata_i;
            default:      mapped   = 1'b0;
        endcase
    end

    // Error only during an access phase that hits a hole in the map
    assign pslverr_o = access & ~mapped;

endmodule

//--- logic/soc_periph_pkg.sv
package soc_periph_pkg;

    // APB widths
    localparam int APB_AW = 32;
    localparam int APB_DW = 32;

    // Address field widths
    localparam int REGION_W  = 4;
    localparam int REG_IDX_W = 6;

    // APB address word, seen raw or split into its fields
    typedef union packed {
        logic [APB_AW-1:0] raw;
        struct packed {
            logic [APB_AW-REGION_W-REG_IDX_W-3:0] upper;
            logic [REGION_W-1:0]                  region;
            logic [REG_IDX_W-1:0]                 reg_idx;
            logic [1:0]                           byte_off;
        } f;
    } periph_addr_u;

    ////////////////////////////////////////
    // Address map
    ////////////////////////////////////////
    localparam logic [REGION_W-1:0] REGION_GPIO  = 4'd0;
    localparam logic [REGION_W-1:0] REGION_TIMER = 4'd1;
    localparam logic [REGION_W-1:0] REGION_SWEVT = 4'd2;

    localparam logic [REG_IDX_W-1:0] GPIO_DIR        = 6'd0;
    localparam logic [REG_IDX_W-1:0] GPIO_OUT        = 6'd1;
    localparam logic [REG_IDX_W-1:0] GPIO_IN         = 6'd2;
    localparam logic [REG_IDX_W-1:0] GPIO_IRQ_EN     = 6'd3;
    localparam logic [REG_IDX_W-1:0] GPIO_IRQ_STATUS = 6'd4;

    // Bit 0 of CTRL enables the timer
    localparam logic [REG_IDX_W-1:0] TMR_CTRL    = 6'd0;
    localparam logic [REG_IDX_W-1:0] TMR_COUNT   = 6'd1;
    localparam logic [REG_IDX_W-1:0] TMR_COMPARE = 6'd2;

    ////////////////////////////////////////
    // Fabric-controller events
    ////////////////////////////////////////
    localparam int SWEVT_W  = 8;
    localparam int FC_EVT_W = 32;

    localparam int EVT_DMA_PE   = 8;
    localparam int EVT_DMA_IRQ  = 9;
    localparam int EVT_TIMER    = 10;
    localparam int EVT_PF       = 12;
    localparam int EVT_REF_EDGE = 14;
    localparam int EVT_GPIO     = 15;

    localparam int NGPIO_DEFAULT = 32;

endpackage
